//--- Makefile
VERILATOR ?= verilator
TOP       := tb_lb_reg_ctrl
FILELIST  := lb_ctrl.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --timescale 1ns/1ps

SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard source/*.sv source/*.svh testbench/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- lb_ctrl.f
+incdir+source
source/lb_ctrl_pkg.sv
source/lb_sync.sv
source/lb_bus_port.sv
source/lb_ctrl_regs.sv
source/lb_status_mux.sv
source/lb_reg_ctrl.sv
testbench/tb_lb_reg_ctrl.sv

//--- source/lb_bus_port.sv
`timescale 1ns/1ps
`include "lb_ctrl_defines.svh"
`default_nettype none

module lb_bus_port
    import lb_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  lbus_strobe_t          strobe,    // already synchronized
    input  logic [`LB_ADDR_W-1:0] addr,
    input  logic [`LB_DATA_W-1:0] d_in,
    input  logic [`LB_DATA_W-1:0] rdata,
    output lbus_wr_t              wr,
    output logic                  rd_active,
    output logic [`LB_DATA_W-1:0] d_out,
    output logic                  d_oe,
    output logic                  rdy_n
);
    logic                  wr_active;
    logic                  wr_active_q;
    logic [`LB_ADDR_W-1:0] wr_addr;
    logic [`LB_DATA_W-1:0] wr_data;
    logic [`LB_DATA_W-1:0] rd_data;

    assign rd_active = !strobe.cs_n && !strobe.rd_n;
    assign wr_active = !strobe.cs_n && !strobe.wr_n;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_active_q <= 1'b0;
            rd_data     <= '0;
        end
        else
        begin
            wr_active_q <= wr_active;
            if (rd_active)
                rd_data <= rdata;        // follows the address while reading
        end
    end

    // keep sampling until the strobe ends, last sample wins
    always_ff @(posedge clk)
    begin
        if (wr_active)
        begin
            wr_addr <= addr;
            wr_data <= d_in;
        end
    end

    // commit on the first cycle after the write strobe is seen high again
    assign wr = '{commit: wr_active_q && !wr_active, addr: wr_addr, data: wr_data};

    assign d_out = rd_data;
    assign d_oe  = rd_active;
    assign rdy_n = !(rd_active || wr_active);   // only reports a seen access

    a_no_commit_in_read: assert property (@(posedge clk) disable iff (!rst_n)
        wr.commit |-> !rd_active);

    a_oe_has_ready: assert property (@(posedge clk) disable iff (!rst_n)
        d_oe |-> !rdy_n);

endmodule

`default_nettype wire

//--- source/lb_ctrl_defines.svh
`ifndef LB_CTRL_DEFINES_SVH
`define LB_CTRL_DEFINES_SVH

`default_nettype none

`define LB_ADDR_W                 10
`define LB_DATA_W                 8
`define LB_SFP_PORTS              8
`define LB_INT_MASK_W             3

// register map
`define LB_ADDR_DATA_WIDTH        10'h000
`define LB_ADDR_CPLD_TEST         10'h001
`define LB_ADDR_VERSION           10'h002
`define LB_ADDR_MONTH             10'h003
`define LB_ADDR_DATE              10'h004
`define LB_ADDR_PCB               10'h005
`define LB_ADDR_BOARD             10'h006
`define LB_ADDR_CONFIG            10'h007
`define LB_ADDR_INT_SOURCE        10'h027
`define LB_ADDR_INT_MASK          10'h028
`define LB_ADDR_DEBUG_LED         10'h02f
`define LB_ADDR_CPLD_TDO          10'h038
`define LB_ADDR_CPLD_TDI          10'h039
`define LB_ADDR_CPLD_TMS          10'h03b
`define LB_ADDR_CPLD_TCK          10'h03c
`define LB_ADDR_TXDIS             10'h040
`define LB_ADDR_LED_LINK          10'h041
`define LB_ADDR_LED_ACT           10'h042
`define LB_ADDR_JTAG_SEL          10'h043
`define LB_ADDR_SFP_ABS           10'h050
`define LB_ADDR_SFP_LOS           10'h051
`define LB_ADDR_SFP_ABS_INT       10'h052
`define LB_ADDR_SFP_LOS_INT       10'h053

// board identity, read only
`define LB_ID_DATA_WIDTH          8'h00
`define LB_ID_VERSION             8'h05
`define LB_ID_MONTH               8'hac
`define LB_ID_DATE                8'h11
`define LB_ID_PCB                 8'h01
`define LB_ID_BOARD               8'h01
`define LB_ID_CONFIG              8'h00

// control register reset values
`define LB_RST_CPLD_TEST          8'h00
`define LB_RST_DEBUG_LED          8'h01
`define LB_RST_INT_MASK           3'b000
`define LB_RST_TXDIS              8'hff
`define LB_RST_LED_LINK           8'hff
`define LB_RST_LED_ACT            8'hff
`define LB_RST_JTAG_SEL           1'b0
`define LB_RST_TCK                1'b0
`define LB_RST_TDI                1'b1
`define LB_RST_TMS                1'b1

`default_nettype wire

`endif

//--- source/lb_ctrl_pkg.sv
`include "lb_ctrl_defines.svh"
`default_nettype none

package lb_ctrl_pkg;

    typedef struct packed {
        logic cs_n;                          // chip select
        logic rd_n;
        logic wr_n;
    } lbus_strobe_t;

    typedef struct packed {
        logic [`LB_SFP_PORTS-1:0] abs;       // module absent pins
        logic [`LB_SFP_PORTS-1:0] los;       // loss of signal pins
        logic [`LB_SFP_PORTS-1:0] abs_evt;   // active low event lines
        logic [`LB_SFP_PORTS-1:0] los_evt;
    } sfp_status_t;

    typedef struct packed {
        logic tck;
        logic tdi;
        logic tms;
    } jtag_drive_t;

    typedef struct packed {
        logic [`LB_DATA_W-1:0]     cpld_test;  // holds inverted write data
        logic [`LB_DATA_W-1:0]     debug_led;
        logic [`LB_INT_MASK_W-1:0] int_mask;
        logic [`LB_DATA_W-1:0]     txdis;
        logic [`LB_DATA_W-1:0]     led_link;
        logic [`LB_DATA_W-1:0]     led_act;
        logic                      jtag_sel;
        jtag_drive_t               jtag;
    } ctrl_regs_t;

    typedef struct packed {
        logic                  commit;     // one cycle write pulse
        logic [`LB_ADDR_W-1:0] addr;
        logic [`LB_DATA_W-1:0] data;
    } lbus_wr_t;

endpackage

`default_nettype wire

//--- source/lb_ctrl_regs.sv
`timescale 1ns/1ps
`include "lb_ctrl_defines.svh"
`default_nettype none

module lb_ctrl_regs
    import lb_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  lbus_wr_t   wr,
    output ctrl_regs_t regs
);
    localparam ctrl_regs_t regs_rst = '{
        cpld_test: `LB_RST_CPLD_TEST,
        debug_led: `LB_RST_DEBUG_LED,
        int_mask:  `LB_RST_INT_MASK,
        txdis:     `LB_RST_TXDIS,        // lasers off until software enables
        led_link:  `LB_RST_LED_LINK,
        led_act:   `LB_RST_LED_ACT,
        jtag_sel:  `LB_RST_JTAG_SEL,
        jtag:      '{tck: `LB_RST_TCK, tdi: `LB_RST_TDI, tms: `LB_RST_TMS}
    };

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            regs <= regs_rst;
        end
        else if (wr.commit)
        begin
            case (wr.addr)
                `LB_ADDR_CPLD_TEST:
                    regs.cpld_test <= ~wr.data;   // host checks the inversion
                `LB_ADDR_INT_MASK:
                    regs.int_mask <= wr.data[`LB_INT_MASK_W-1:0];
                `LB_ADDR_DEBUG_LED:
                    regs.debug_led <= wr.data;
                `LB_ADDR_CPLD_TDI:
                    regs.jtag.tdi <= wr.data[0];
                `LB_ADDR_CPLD_TMS:
                    regs.jtag.tms <= wr.data[0];
                `LB_ADDR_CPLD_TCK:
                    regs.jtag.tck <= wr.data[0];  // host bit-bangs the clock
                `LB_ADDR_TXDIS:
                    regs.txdis <= wr.data;
                `LB_ADDR_LED_LINK:
                    regs.led_link <= wr.data;
                `LB_ADDR_LED_ACT:
                    regs.led_act <= wr.data;
                `LB_ADDR_JTAG_SEL:
                    regs.jtag_sel <= wr.data[0];
                default:
                    regs <= regs;                 // read-only or unmapped
            endcase
        end
    end

    a_int_mask_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr.commit && wr.addr == `LB_ADDR_INT_MASK
        |=> regs.int_mask == $past(wr.data[`LB_INT_MASK_W-1:0]));

endmodule

`default_nettype wire

//--- source/lb_reg_ctrl.sv
`timescale 1ns/1ps
`include "lb_ctrl_defines.svh"
`default_nettype none

module lb_reg_ctrl
    import lb_ctrl_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`LB_ADDR_W-1:0]    lbus_a,
    input  logic [`LB_DATA_W-1:0]    lbus_d_in,
    input  logic                     lbus_cs_n,
    input  logic                     lbus_rd_n,
    input  logic                     lbus_wr_n,
    output logic [`LB_DATA_W-1:0]    lbus_d_out,
    output logic                     lbus_d_oe,    // pad enable, pad is outside
    output logic                     lbus_rdy_n,
    output logic                     lbus_int_n,
    input  logic [`LB_SFP_PORTS-1:0] sfp_abs,
    input  logic [`LB_SFP_PORTS-1:0] sfp_los,
    input  logic [`LB_SFP_PORTS-1:0] sfp_abs_evt,
    input  logic [`LB_SFP_PORTS-1:0] sfp_los_evt,
    input  logic                     tdo,
    input  logic                     lm80_n,
    input  logic                     sfp_abs_int,
    input  logic                     sfp_los_int,
    output logic [`LB_DATA_W-1:0]    txdis,
    output logic [`LB_DATA_W-1:0]    led_link,
    output logic [`LB_DATA_W-1:0]    led_act,
    output logic [`LB_DATA_W-1:0]    debug_led,
    output logic                     jtag_sel,
    output logic                     cpld_tck,
    output logic                     cpld_tdi,
    output logic                     cpld_tms,
    output logic                     reading_abs_int,
    output logic                     reading_los_int
);
    lbus_strobe_t          strobe_raw;
    lbus_strobe_t          strobe;
    sfp_status_t           sfp_raw;
    sfp_status_t           sfp;
    lbus_wr_t              wr;
    ctrl_regs_t            regs;
    logic                  rd_active;
    logic [`LB_DATA_W-1:0] rdata;

    assign strobe_raw = '{cs_n: lbus_cs_n, rd_n: lbus_rd_n, wr_n: lbus_wr_n};
    assign sfp_raw    = '{abs: sfp_abs, los: sfp_los, abs_evt: sfp_abs_evt, los_evt: sfp_los_evt};

    // strobes idle high out of reset
    lb_sync #(.payload_t(lbus_strobe_t), .reset_val(lbus_strobe_t'('1))) u_strobe_sync (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (strobe_raw),
        .q     (strobe)
    );

    lb_sync #(.payload_t(sfp_status_t)) u_sfp_sync (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (sfp_raw),
        .q     (sfp)
    );

    lb_bus_port u_bus_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .strobe    (strobe),
        .addr      (lbus_a),
        .d_in      (lbus_d_in),
        .rdata     (rdata),
        .wr        (wr),
        .rd_active (rd_active),
        .d_out     (lbus_d_out),
        .d_oe      (lbus_d_oe),
        .rdy_n     (lbus_rdy_n)
    );

    lb_ctrl_regs u_ctrl_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr),
        .regs  (regs)
    );

    lb_status_mux u_status_mux (
        .addr            (lbus_a),
        .rd_active       (rd_active),
        .regs            (regs),
        .sfp             (sfp),
        .tdo             (tdo),
        .lm80_n          (lm80_n),
        .sfp_abs_int     (sfp_abs_int),
        .sfp_los_int     (sfp_los_int),
        .rdata           (rdata),
        .int_n           (lbus_int_n),
        .reading_abs_int (reading_abs_int),
        .reading_los_int (reading_los_int)
    );

    assign txdis     = regs.txdis;
    assign led_link  = regs.led_link;
    assign led_act   = regs.led_act;
    assign debug_led = regs.debug_led;
    assign jtag_sel  = regs.jtag_sel;
    assign cpld_tck  = regs.jtag.tck;
    assign cpld_tdi  = regs.jtag.tdi;
    assign cpld_tms  = regs.jtag.tms;

endmodule

`default_nettype wire

//--- source/lb_status_mux.sv
`timescale 1ns/1ps
`include "lb_ctrl_defines.svh"
`default_nettype none

module lb_status_mux
    import lb_ctrl_pkg::*;
(
    input  logic [`LB_ADDR_W-1:0] addr,
    input  logic                  rd_active,
    input  ctrl_regs_t            regs,
    input  sfp_status_t           sfp,        // synchronized pin state
    input  logic                  tdo,
    input  logic                  lm80_n,
    input  logic                  sfp_abs_int,
    input  logic                  sfp_los_int,
    output logic [`LB_DATA_W-1:0] rdata,
    output logic                  int_n,
    output logic                  reading_abs_int,
    output logic                  reading_los_int
);
    logic       lm80_int;
    logic [2:0] int_src;

    assign lm80_int = !lm80_n && !regs.int_mask[2];   // sensor alarm, maskable
    assign int_src  = {lm80_int, sfp_los_int, sfp_abs_int};
    assign int_n    = !(|int_src);

    always_comb
    begin
        case (addr)
            `LB_ADDR_DATA_WIDTH:  rdata = `LB_ID_DATA_WIDTH;
            `LB_ADDR_CPLD_TEST:   rdata = regs.cpld_test;
            `LB_ADDR_VERSION:     rdata = `LB_ID_VERSION;
            `LB_ADDR_MONTH:       rdata = `LB_ID_MONTH;
            `LB_ADDR_DATE:        rdata = `LB_ID_DATE;
            `LB_ADDR_PCB:         rdata = `LB_ID_PCB;
            `LB_ADDR_BOARD:       rdata = `LB_ID_BOARD;
            `LB_ADDR_CONFIG:      rdata = `LB_ID_CONFIG;
            `LB_ADDR_INT_SOURCE:  rdata = {5'b0, int_src};
            `LB_ADDR_INT_MASK:    rdata = {5'b0, regs.int_mask};
            `LB_ADDR_DEBUG_LED:   rdata = regs.debug_led;
            `LB_ADDR_CPLD_TDO:    rdata = {7'b0, tdo};
            `LB_ADDR_TXDIS:       rdata = regs.txdis;
            `LB_ADDR_LED_LINK:    rdata = regs.led_link;
            `LB_ADDR_LED_ACT:     rdata = regs.led_act;
            `LB_ADDR_JTAG_SEL:    rdata = {7'b0, regs.jtag_sel};
            `LB_ADDR_SFP_ABS:     rdata = sfp.abs;
            `LB_ADDR_SFP_LOS:     rdata = sfp.los;
            `LB_ADDR_SFP_ABS_INT: rdata = ~sfp.abs_evt;   // event lines are active low
            `LB_ADDR_SFP_LOS_INT: rdata = ~sfp.los_evt;
            default:              rdata = '0;
        endcase
    end

    // lets the event logic clear its flags once the host has looked
    assign reading_abs_int = rd_active && (addr == `LB_ADDR_SFP_ABS_INT);
    assign reading_los_int = rd_active && (addr == `LB_ADDR_SFP_LOS_INT);

endmodule

`default_nettype wire

//--- source/lb_sync.sv
`timescale 1ns/1ps
`default_nettype none

module lb_sync #(
    parameter type      payload_t = logic,
    parameter payload_t reset_val = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t d,
    output payload_t q
);
    payload_t meta;                          // first stage, may go metastable

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            meta <= reset_val;
            q    <= reset_val;
        end
        else
        begin
            meta <= d;
            q    <= meta;
        end
    end

    // once both stages have left reset, q is d from two edges back
    a_two_stage: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) && $past(rst_n, 2) |-> q == $past(d, 2));

endmodule

`default_nettype wire

//--- testbench/tb_lb_reg_ctrl.sv
`timescale 1ns/1ps
`include "lb_ctrl_defines.svh"
`default_nettype none

module tb_lb_reg_ctrl;
    localparam int timeout_cycles = 20;
    localparam logic [`LB_ADDR_W-1:0] byte_regs [4] = '{
        `LB_ADDR_TXDIS, `LB_ADDR_LED_LINK, `LB_ADDR_LED_ACT, `LB_ADDR_DEBUG_LED
    };
    localparam logic [`LB_ADDR_W-1:0] jtag_regs [3] = '{
        `LB_ADDR_CPLD_TDI, `LB_ADDR_CPLD_TMS, `LB_ADDR_CPLD_TCK
    };

    logic                     clk;
    logic                     rst_n;
    logic [`LB_ADDR_W-1:0]    lbus_a;
    logic [`LB_DATA_W-1:0]    lbus_d_in;
    logic                     lbus_cs_n;
    logic                     lbus_rd_n;
    logic                     lbus_wr_n;
    logic [`LB_DATA_W-1:0]    lbus_d_out;
    logic                     lbus_d_oe;
    logic                     lbus_rdy_n;
    logic                     lbus_int_n;
    logic [`LB_SFP_PORTS-1:0] sfp_abs;
    logic [`LB_SFP_PORTS-1:0] sfp_los;
    logic [`LB_SFP_PORTS-1:0] sfp_abs_evt;
    logic [`LB_SFP_PORTS-1:0] sfp_los_evt;
    logic                     tdo;
    logic                     lm80_n;
    logic                     sfp_abs_int;
    logic                     sfp_los_int;
    logic [`LB_DATA_W-1:0]    txdis;
    logic [`LB_DATA_W-1:0]    led_link;
    logic [`LB_DATA_W-1:0]    led_act;
    logic [`LB_DATA_W-1:0]    debug_led;
    logic                     jtag_sel;
    logic                     cpld_tck;
    logic                     cpld_tdi;
    logic                     cpld_tms;
    logic                     reading_abs_int;
    logic                     reading_los_int;
    logic [31:0]              rng_state;

    lb_reg_ctrl UUT (.*);

    always #50 clk = ~clk;                   // 100 ns period

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic rand_byte(output logic [7:0] r);
        rng_state = xorshift(rng_state);
        r = rng_state[7:0];
    endtask

    // byte shown on the pins behind a writable address
    function automatic logic [7:0] pin_value(input logic [`LB_ADDR_W-1:0] addr);
        case (addr)
            `LB_ADDR_TXDIS:     return txdis;
            `LB_ADDR_LED_LINK:  return led_link;
            `LB_ADDR_LED_ACT:   return led_act;
            `LB_ADDR_DEBUG_LED: return debug_led;
            `LB_ADDR_JTAG_SEL:  return {7'b0, jtag_sel};
            `LB_ADDR_CPLD_TDI:  return {7'b0, cpld_tdi};
            `LB_ADDR_CPLD_TMS:  return {7'b0, cpld_tms};
            `LB_ADDR_CPLD_TCK:  return {7'b0, cpld_tck};
            default:            return 8'h00;
        endcase
    endfunction

    task automatic compare_byte(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
        assert (actual === expected)
        else
        begin
            $display("MISMATCH at time %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "value check on %s failed", name);
        end
    endtask

    task automatic fail_on_timeout(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, timeout_cycles);
        $display("Simulation finished: FAIL");
        $fatal(1, "wait timed out");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;                                  // drive and sample just after the edge
    endtask

    task automatic wait_ready(output int n);
        n = 0;
        while (lbus_rdy_n !== 1'b0)
        begin
            if (n == timeout_cycles)
                fail_on_timeout("lbus_rdy_n going low");
            next_cycle();
            n++;
        end
    endtask

    task automatic wait_pin(input logic [`LB_ADDR_W-1:0] addr, input logic [7:0] expected);
        int n;
        n = 0;
        while (pin_value(addr) !== expected)
        begin
            if (n == timeout_cycles)
                fail_on_timeout($sformatf("pin update for address %h", addr));
            next_cycle();
            n++;
        end
    endtask

    task automatic wait_int_n(input logic level);
        int n;
        n = 0;
        while (lbus_int_n !== level)
        begin
            if (n == timeout_cycles)
                fail_on_timeout($sformatf("lbus_int_n reaching %b", level));
            next_cycle();
            n++;
        end
    endtask

    task automatic bus_write(input logic [`LB_ADDR_W-1:0] addr, input logic [7:0] data);
        int n;
        lbus_a    = addr;
        lbus_d_in = data;
        lbus_cs_n = 1'b0;
        lbus_wr_n = 1'b0;
        wait_ready(n);
        repeat (6 - n) next_cycle();         // strobe low 6 cycles in all
        lbus_cs_n = 1'b1;
        lbus_wr_n = 1'b1;
        repeat (6) next_cycle();             // address and data stay put until commit
    endtask

    task automatic bus_read(input logic [`LB_ADDR_W-1:0] addr, output logic [7:0] data);
        int n;
        lbus_a    = addr;
        lbus_cs_n = 1'b0;
        lbus_rd_n = 1'b0;
        wait_ready(n);
        repeat (5 - n) next_cycle();         // last cycle before release
        compare_byte("lbus_d_oe", 8'h01, {7'b0, lbus_d_oe});
        compare_byte("reading_abs_int", {7'b0, addr == 10'h052}, {7'b0, reading_abs_int});
        compare_byte("reading_los_int", {7'b0, addr == 10'h053}, {7'b0, reading_los_int});
        data = lbus_d_out;
        next_cycle();
        lbus_cs_n = 1'b1;
        lbus_rd_n = 1'b1;
        repeat (6) next_cycle();
        compare_byte("lbus_d_oe idle", 8'h00, {7'b0, lbus_d_oe});
        compare_byte("reading flags idle", 8'h00, {6'b0, reading_abs_int, reading_los_int});
    endtask

    task automatic read_expect(input logic [`LB_ADDR_W-1:0] addr, input logic [7:0] expected);
        logic [7:0] got;
        bus_read(addr, got);
        compare_byte($sformatf("lbus_d_out at %h", addr), expected, got);
    endtask

    initial
    begin
        logic [7:0] d;
        clk = 1'b0;
        rst_n = 1'b0;
        lbus_a = '0;
        lbus_d_in = '0;
        lbus_cs_n = 1'b1;
        lbus_rd_n = 1'b1;
        lbus_wr_n = 1'b1;
        sfp_abs = '0;
        sfp_los = '0;
        sfp_abs_evt = '1;
        sfp_los_evt = '1;
        tdo = 1'b0;
        lm80_n = 1'b1;
        sfp_abs_int = 1'b0;
        sfp_los_int = 1'b0;
        rng_state = 32'h4f3d;
        repeat (10) next_cycle();
        rst_n = 1'b1;
        repeat (2) next_cycle();

        // identity and reset state
        compare_byte("lbus_d_oe", 8'h00, {7'b0, lbus_d_oe});
        compare_byte("lbus_rdy_n", 8'h01, {7'b0, lbus_rdy_n});
        compare_byte("txdis", 8'hff, txdis);
        compare_byte("led_link", 8'hff, led_link);
        compare_byte("led_act", 8'hff, led_act);
        compare_byte("debug_led", 8'h01, debug_led);
        compare_byte("jtag pins tck tdi tms", 8'h03, {5'b0, cpld_tck, cpld_tdi, cpld_tms});
        read_expect(10'h000, `LB_ID_DATA_WIDTH);
        read_expect(10'h002, `LB_ID_VERSION);
        read_expect(10'h003, `LB_ID_MONTH);
        read_expect(10'h004, `LB_ID_DATE);
        read_expect(10'h005, `LB_ID_PCB);
        read_expect(10'h006, `LB_ID_BOARD);
        read_expect(10'h007, `LB_ID_CONFIG);

        // control registers and the inverting test register
        repeat (3)
        begin
            foreach (byte_regs[i])
            begin
                rand_byte(d);
                bus_write(byte_regs[i], d);
                wait_pin(byte_regs[i], d);
                read_expect(byte_regs[i], d);
            end
            rand_byte(d);
            bus_write(10'h043, d);
            wait_pin(10'h043, {7'b0, d[0]});
            read_expect(10'h043, {7'b0, d[0]});
            rand_byte(d);
            bus_write(10'h001, d);
            read_expect(10'h001, ~d);
        end

        // jtag bit-bang, both levels on every pin
        foreach (jtag_regs[i])
        begin
            rand_byte(d);
            bus_write(jtag_regs[i], d);
            wait_pin(jtag_regs[i], {7'b0, d[0]});
            d = d ^ 8'h01;                   // other level next
            bus_write(jtag_regs[i], d);
            wait_pin(jtag_regs[i], {7'b0, d[0]});
        end
        tdo = 1'b0;
        read_expect(10'h038, 8'h00);
        tdo = 1'b1;
        read_expect(10'h038, 8'h01);

        // sfp status, event registers and unmapped space
        repeat (3)
        begin
            rand_byte(d);
            sfp_abs = d;
            rand_byte(d);
            sfp_los = d;
            rand_byte(d);
            sfp_abs_evt = d;
            rand_byte(d);
            sfp_los_evt = d;
            read_expect(10'h050, sfp_abs);
            read_expect(10'h051, sfp_los);
            read_expect(10'h052, ~sfp_abs_evt);
            read_expect(10'h053, ~sfp_los_evt);
        end
        read_expect(10'h00d, 8'h00);
        read_expect(10'h044, 8'h00);
        read_expect(10'h3ff, 8'h00);

        // interrupt sources and mask
        lm80_n = 1'b0;
        wait_int_n(1'b0);
        read_expect(10'h027, 8'h04);
        bus_write(10'h028, 8'h04);
        wait_int_n(1'b1);
        read_expect(10'h028, 8'h04);
        read_expect(10'h027, 8'h00);
        sfp_abs_int = 1'b1;
        wait_int_n(1'b0);
        read_expect(10'h027, 8'h01);
        sfp_abs_int = 1'b0;
        wait_int_n(1'b1);
        sfp_los_int = 1'b1;
        wait_int_n(1'b0);
        read_expect(10'h027, 8'h02);
        sfp_los_int = 1'b0;
        wait_int_n(1'b1);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
